//--- logic/arcade_pkg.sv
package arcade_pkg;

	// ============================================================
	// Control vectors
	// ============================================================
	localparam int JOY_W  = 8;
	localparam int CTRL_W = 5;
	localparam int SW_W   = 3;

	// Bit order shared by joystick words and control vectors
	localparam int CTRL_RIGHT = 0;
	localparam int CTRL_LEFT  = 1;
	localparam int CTRL_DOWN  = 2;
	localparam int CTRL_UP    = 3;
	localparam int CTRL_FIRE  = 4;

	// Game switch bits
	localparam int SW_COIN   = 0;
	localparam int SW_START1 = 1;
	localparam int SW_START2 = 2;

	typedef logic [JOY_W-1:0]  joy_t;
	typedef logic [CTRL_W-1:0] ctrl_t;
	typedef logic [SW_W-1:0]   sw_t;

	// ============================================================
	// Keyboard events
	// ============================================================
	localparam int KEY_CODE_W      = 8;
	localparam int KEY_EVENT_W     = 11;
	localparam int KEY_PRESSED_BIT = 9;
	localparam int KEY_TOGGLE_BIT  = 10;

	typedef logic [KEY_CODE_W-1:0]  key_code_t;
	typedef logic [KEY_EVENT_W-1:0] key_event_t;

	localparam key_code_t KEY_UP     = 8'h75;
	localparam key_code_t KEY_DOWN   = 8'h72;
	localparam key_code_t KEY_LEFT   = 8'h6B;
	localparam key_code_t KEY_RIGHT  = 8'h74;
	localparam key_code_t KEY_FIRE   = 8'h29; // Space
	localparam key_code_t KEY_COIN   = 8'h76; // Esc
	localparam key_code_t KEY_START1 = 8'h05; // F1
	localparam key_code_t KEY_START2 = 8'h06; // F2

	// ============================================================
	// Video and audio
	// ============================================================
	typedef logic [2:0] rgb3_t;
	typedef logic [1:0] rgb2_t;
	typedef logic [5:0] vga_t;

	localparam int AUDIO_W = 8;
	typedef logic [AUDIO_W-1:0] audio_t;

	localparam int CE_DIV   = 4; // System clocks per pixel
	localparam int CE_CNT_W = $clog2(CE_DIV);
	typedef logic [CE_CNT_W-1:0] ce_cnt_t;

endpackage

//--- logic/host_pkg.sv
package host_pkg;

	// APB bus widths
	localparam int APB_ADDR_W = 4;
	localparam int APB_DATA_W = 32;

	typedef logic [APB_ADDR_W-1:0] apb_addr_t;
	typedef logic [APB_DATA_W-1:0] apb_data_t;

	// ============================================================
	// Register map
	// ============================================================
	localparam apb_addr_t ADDR_CTRL   = 4'h0;
	localparam apb_addr_t ADDR_STATUS = 4'h4;

	// Control register layout
	localparam int CTRL_REG_W      = 4;
	localparam int CTRL_RESET_BIT  = 0;
	localparam int CTRL_ROTATE_BIT = 1;
	localparam int CTRL_SCAN_LSB   = 2;
	localparam int CTRL_SCAN_W     = 2;

	typedef logic [CTRL_REG_W-1:0]  ctrl_reg_t;
	typedef logic [CTRL_SCAN_W-1:0] scan_t;

	// Status register layout, merged controls sit in the low bits
	localparam int STAT_CTRL_LSB   = 0;
	localparam int STAT_COIN_BIT   = 5;
	localparam int STAT_START1_BIT = 6;
	localparam int STAT_START2_BIT = 7;

endpackage

//--- logic/ps2_key_decoder.sv
`timescale 1ns/1ps

module ps2_key_decoder
	import arcade_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  key_event_t key_event,
	output ctrl_t      kb_ctrl,
	output logic       kb_coin,
	output logic       kb_start1,
	output logic       kb_start2
);

	logic      toggle_q; // Toggle bit seen on the previous clock
	logic      new_event;
	logic      pressed;
	key_code_t code;

	assign code      = key_event[KEY_CODE_W-1:0];
	assign pressed   = key_event[KEY_PRESSED_BIT];
	assign new_event = key_event[KEY_TOGGLE_BIT] != toggle_q;

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			toggle_q <= 1'b0;
		end else begin
			toggle_q <= key_event[KEY_TOGGLE_BIT];
		end
	end

	// ============================================================
	// Held button states
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			kb_ctrl   <= '0;
			kb_coin   <= 1'b0;
			kb_start1 <= 1'b0;
			kb_start2 <= 1'b0;
		end else if (new_event) begin
			case (code)
				KEY_UP:     kb_ctrl[CTRL_UP]    <= pressed;
				KEY_DOWN:   kb_ctrl[CTRL_DOWN]  <= pressed;
				KEY_LEFT:   kb_ctrl[CTRL_LEFT]  <= pressed;
				KEY_RIGHT:  kb_ctrl[CTRL_RIGHT] <= pressed;
				KEY_FIRE:   kb_ctrl[CTRL_FIRE]  <= pressed;
				KEY_COIN:   kb_coin             <= pressed;
				KEY_START1: kb_start1           <= pressed;
				KEY_START2: kb_start2           <= pressed;
				default: begin
					// Other keys are ignored
				end
			endcase
		end
	end

endmodule

//--- logic/control_mapper.sv
`timescale 1ns/1ps

module control_mapper
	import arcade_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst_n,
	input  ctrl_t kb_ctrl,
	input  logic  kb_coin,
	input  logic  kb_start1,
	input  logic  kb_start2,
	input  joy_t  joy0,
	input  joy_t  joy1,
	input  logic  rotate,
	output ctrl_t game_ctrl_n,
	output sw_t   game_sw,
	output ctrl_t merged_ctrl
);

	ctrl_t merged;
	ctrl_t mapped;

	// Keyboard and both sticks act as one controller
	assign merged = kb_ctrl | joy0[CTRL_W-1:0] | joy1[CTRL_W-1:0];

	// Quarter turn for a vertical screen
	always_comb begin
		mapped = merged;
		if (rotate) begin
			mapped[CTRL_UP]    = merged[CTRL_LEFT];
			mapped[CTRL_DOWN]  = merged[CTRL_RIGHT];
			mapped[CTRL_LEFT]  = merged[CTRL_DOWN];
			mapped[CTRL_RIGHT] = merged[CTRL_UP];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			game_ctrl_n <= '1; // Nothing pressed
			game_sw     <= '0;
			merged_ctrl <= '0;
		end else begin
			game_ctrl_n <= ~mapped; // Core expects active low
			game_sw[SW_COIN]   <= kb_coin;
			game_sw[SW_START1] <= kb_start1;
			game_sw[SW_START2] <= kb_start2;
			merged_ctrl <= merged;
		end
	end

endmodule

//--- logic/host_regs.sv
`timescale 1ns/1ps

module host_regs
	import arcade_pkg::*, host_pkg::*;
(
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      psel,
	input  logic      penable,
	input  logic      pwrite,
	input  apb_addr_t paddr,
	input  apb_data_t pwdata,
	output apb_data_t prdata,
	input  ctrl_t     merged_ctrl,
	input  logic      kb_coin,
	input  logic      kb_start1,
	input  logic      kb_start2,
	output logic      core_reset,
	output logic      rotate,
	output scan_t     scanlines
);

	ctrl_reg_t ctrl_q;
	apb_data_t status_word;
	logic      access;

	// Access phase, no wait states
	assign access = psel & penable;

	// ============================================================
	// Control register
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			ctrl_q <= '0;
		end else if (access && pwrite && paddr == ADDR_CTRL) begin
			ctrl_q <= pwdata[CTRL_REG_W-1:0];
		end
	end

	assign core_reset = ctrl_q[CTRL_RESET_BIT];
	assign rotate     = ctrl_q[CTRL_ROTATE_BIT];
	assign scanlines  = ctrl_q[CTRL_SCAN_LSB +: CTRL_SCAN_W];

	// ============================================================
	// Live input status
	// ============================================================
	always_comb begin
		status_word = '0;
		status_word[STAT_CTRL_LSB +: CTRL_W] = merged_ctrl;
		status_word[STAT_COIN_BIT]   = kb_coin;
		status_word[STAT_START1_BIT] = kb_start1;
		status_word[STAT_START2_BIT] = kb_start2;
	end

	// Read mux, unmapped offsets return zero
	always_comb begin
		prdata = '0;
		if (psel && !pwrite) begin
			case (paddr)
				ADDR_CTRL:   prdata = apb_data_t'(ctrl_q);
				ADDR_STATUS: prdata = status_word;
				default:     prdata = '0;
			endcase
		end
	end

endmodule

//--- logic/pixel_gate.sv
`timescale 1ns/1ps

module pixel_gate
	import arcade_pkg::*;
(
	input  logic  clk_sys,
	input  logic  rst_n,
	input  rgb3_t core_r,
	input  rgb3_t core_g,
	input  rgb2_t core_b,
	input  logic  hblank,
	input  logic  vblank,
	output logic  ce_pix,
	output vga_t  vga_r,
	output vga_t  vga_g,
	output vga_t  vga_b
);

	ce_cnt_t div_q;
	logic    blank;

	// Free running pixel divider
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			div_q <= '0;
		end else begin
			div_q <= div_q + 1'b1; // Wraps at CE_DIV
		end
	end

	assign ce_pix = div_q == ce_cnt_t'(CE_DIV - 1);
	assign blank  = hblank | vblank;

	// ============================================================
	// Colour gating and widening
	// ============================================================
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			vga_r <= '0;
			vga_g <= '0;
			vga_b <= '0;
		end else if (ce_pix) begin
			if (blank) begin
				vga_r <= '0;
				vga_g <= '0;
				vga_b <= '0;
			end else begin
				vga_r <= {core_r, core_r};
				vga_g <= {core_g, core_g};
				vga_b <= {core_b, core_b, core_b}; // 2 bits repeated
			end
		end
	end

endmodule

//--- logic/sigma_delta_dac.sv
`timescale 1ns/1ps

module sigma_delta_dac
	import arcade_pkg::*;
(
	input  logic   clk_sys,
	input  logic   rst_n,
	input  audio_t audio_in,
	output logic   audio_out
);

	audio_t           acc_q;
	logic [AUDIO_W:0] sum; // One extra bit for the carry

	assign sum = {1'b0, acc_q} + {1'b0, audio_in};

	// First order loop, the carry is the output bit
	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			acc_q     <= '0;
			audio_out <= 1'b0;
		end else begin
			acc_q     <= sum[AUDIO_W-1:0];
			audio_out <= sum[AUDIO_W];
		end
	end

endmodule

//--- logic/arcade_frontend.sv
`timescale 1ns/1ps

module arcade_frontend
	import arcade_pkg::*, host_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,
	input  key_event_t key_event,
	input  joy_t       joy0,
	input  joy_t       joy1,
	input  logic       psel,
	input  logic       penable,
	input  logic       pwrite,
	input  apb_addr_t  paddr,
	input  apb_data_t  pwdata,
	output apb_data_t  prdata,
	input  rgb3_t      core_r,
	input  rgb3_t      core_g,
	input  rgb2_t      core_b,
	input  logic       hblank,
	input  logic       vblank,
	input  audio_t     audio_in,
	output ctrl_t      game_ctrl_n,
	output sw_t        game_sw,
	output logic       core_reset,
	output scan_t      scanlines,
	output logic       ce_pix,
	output vga_t       vga_r,
	output vga_t       vga_g,
	output vga_t       vga_b,
	output logic       audio_out
);

	ctrl_t kb_ctrl;
	logic  kb_coin;
	logic  kb_start1;
	logic  kb_start2;
	ctrl_t merged_ctrl;
	logic  rotate;

	// ============================================================
	// Player inputs
	// ============================================================
	ps2_key_decoder ps2_key_decoder_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.key_event (key_event),
		.kb_ctrl   (kb_ctrl),
		.kb_coin   (kb_coin),
		.kb_start1 (kb_start1),
		.kb_start2 (kb_start2)
	);

	control_mapper control_mapper_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.kb_ctrl     (kb_ctrl),
		.kb_coin     (kb_coin),
		.kb_start1   (kb_start1),
		.kb_start2   (kb_start2),
		.joy0        (joy0),
		.joy1        (joy1),
		.rotate      (rotate),
		.game_ctrl_n (game_ctrl_n),
		.game_sw     (game_sw),
		.merged_ctrl (merged_ctrl)
	);

	// Host configuration over APB
	host_regs host_regs_inst (
		.clk_sys     (clk_sys),
		.rst_n       (rst_n),
		.psel        (psel),
		.penable     (penable),
		.pwrite      (pwrite),
		.paddr       (paddr),
		.pwdata      (pwdata),
		.prdata      (prdata),
		.merged_ctrl (merged_ctrl),
		.kb_coin     (kb_coin),
		.kb_start1   (kb_start1),
		.kb_start2   (kb_start2),
		.core_reset  (core_reset),
		.rotate      (rotate),
		.scanlines   (scanlines)
	);

	// ============================================================
	// Video and audio out
	// ============================================================
	pixel_gate pixel_gate_inst (
		.clk_sys (clk_sys),
		.rst_n   (rst_n),
		.core_r  (core_r),
		.core_g  (core_g),
		.core_b  (core_b),
		.hblank  (hblank),
		.vblank  (vblank),
		.ce_pix  (ce_pix),
		.vga_r   (vga_r),
		.vga_g   (vga_g),
		.vga_b   (vga_b)
	);

	sigma_delta_dac sigma_delta_dac_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.audio_in  (audio_in),
		.audio_out (audio_out)
	);

endmodule

//--- dv/arcade_frontend_assert.sv
`timescale 1ns/1ps

module arcade_frontend_assert
	import arcade_pkg::*;
(
	input logic  clk_sys,
	input logic  rst_n,
	input logic  ce_pix,
	input logic  hblank,
	input logic  vblank,
	input vga_t  vga_r,
	input vga_t  vga_g,
	input vga_t  vga_b,
	input ctrl_t game_ctrl_n
);

	int fail_count = 0; // Read by the testbench at the end

	// ============================================================
	// Pixel timing and blanking
	// ============================================================
	ce_single: assert property (@(posedge clk_sys) disable iff (!rst_n)
		ce_pix |=> !ce_pix)
		else begin
			$error("ce_pix high on two cycles in a row");
			fail_count = fail_count + 1;
		end

	blank_black: assert property (@(posedge clk_sys) disable iff (!rst_n)
		(ce_pix && (hblank || vblank)) |=> (vga_r == '0 && vga_g == '0 && vga_b == '0))
		else begin
			$error("Colour not black after a blanked pixel");
			fail_count = fail_count + 1;
		end

	// Core sees no buttons during reset
	reset_idle: assert property (@(posedge clk_sys)
		!rst_n |=> game_ctrl_n == '1)
		else begin
			$error("game_ctrl_n not idle in reset");
			fail_count = fail_count + 1;
		end

endmodule

bind arcade_frontend arcade_frontend_assert arcade_frontend_assert_inst (
	.clk_sys     (clk_sys),
	.rst_n       (rst_n),
	.ce_pix      (ce_pix),
	.hblank      (hblank),
	.vblank      (vblank),
	.vga_r       (vga_r),
	.vga_g       (vga_g),
	.vga_b       (vga_b),
	.game_ctrl_n (game_ctrl_n)
);

//--- dv/arcade_frontend_tb.sv
`timescale 1ns/1ps

module arcade_frontend_tb
	import arcade_pkg::*, host_pkg::*;
;

	localparam int TIMEOUT_CYCLES = 20000; // Tests take about 8000
	localparam int KEY_EVENTS     = 60;
	localparam int JOY_STEPS      = 30;
	localparam int REG_WRITES     = 24;
	localparam int PIXEL_STEPS    = 60;

	logic       clk_sys;
	logic       rst_n;
	key_event_t key_event;
	joy_t       joy0;
	joy_t       joy1;
	logic       psel;
	logic       penable;
	logic       pwrite;
	apb_addr_t  paddr;
	apb_data_t  pwdata;
	apb_data_t  prdata;
	rgb3_t      core_r;
	rgb3_t      core_g;
	rgb2_t      core_b;
	logic       hblank;
	logic       vblank;
	audio_t     audio_in;
	ctrl_t      game_ctrl_n;
	sw_t        game_sw;
	logic       core_reset;
	scan_t      scanlines;
	logic       ce_pix;
	vga_t       vga_r;
	vga_t       vga_g;
	vga_t       vga_b;
	logic       audio_out;

	integer      seed;
	logic [31:0] rnd;
	int          cycle_count = 0;

	// Reference state of the held buttons and the control register
	ctrl_t     kb_ctrl_ref;
	logic      kb_coin_ref;
	logic      kb_start1_ref;
	logic      kb_start2_ref;
	logic      toggle_bit;
	ctrl_reg_t ctrl_ref;
	logic      rotate_ref;

	key_code_t known_keys [8];
	audio_t    audio_levels [5];

	// Video checker state
	logic        vga_pending = 1'b0;
	logic [17:0] vga_expected = '0;
	logic        ce_seen = 1'b0;
	int          since_ce = 0;

	arcade_frontend arcade_frontend_inst (.*);

	initial clk_sys = 1'b0;
	always #5 clk_sys = ~clk_sys;

	// ============================================================
	// Reference model
	// ============================================================
	function automatic ctrl_t expected_ctrl_n(input ctrl_t merged, input logic rot);
		ctrl_t core;
		core = merged;
		if (rot) begin // Quarter turn with fire left alone
			core[CTRL_RIGHT] = merged[CTRL_UP];
			core[CTRL_DOWN]  = merged[CTRL_RIGHT];
			core[CTRL_LEFT]  = merged[CTRL_DOWN];
			core[CTRL_UP]    = merged[CTRL_LEFT];
		end
		return ~core;
	endfunction

	function automatic logic [17:0] expected_rgb(input rgb3_t r, input rgb3_t g,
			input rgb2_t b, input logic blank);
		if (blank) begin
			return '0;
		end
		// Repeating a field is a multiply by 9 or 21
		return {vga_t'(r) * 6'd9, vga_t'(g) * 6'd9, vga_t'(b) * 6'd21};
	endfunction

	task automatic check(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Simulation failed");
			$fatal(1, "Stopping at first mismatch");
		end
	endtask

	// ============================================================
	// Bus and stimulus tasks
	// ============================================================
	task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b1;
		paddr   <= addr;
		pwdata  <= data;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys); // Register takes the data here
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
		@(posedge clk_sys);
		psel    <= 1'b1;
		penable <= 1'b0;
		pwrite  <= 1'b0;
		paddr   <= addr;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(negedge clk_sys);
		data = prdata; // Sampled mid access phase
		@(posedge clk_sys);
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic send_key(input key_code_t code, input logic pressed);
		@(posedge clk_sys);
		toggle_bit = ~toggle_bit; // Marks a new event
		key_event <= {toggle_bit, pressed, 1'b0, code};
		case (code)
			KEY_UP:     kb_ctrl_ref[CTRL_UP]    = pressed;
			KEY_DOWN:   kb_ctrl_ref[CTRL_DOWN]  = pressed;
			KEY_LEFT:   kb_ctrl_ref[CTRL_LEFT]  = pressed;
			KEY_RIGHT:  kb_ctrl_ref[CTRL_RIGHT] = pressed;
			KEY_FIRE:   kb_ctrl_ref[CTRL_FIRE]  = pressed;
			KEY_COIN:   kb_coin_ref             = pressed;
			KEY_START1: kb_start1_ref           = pressed;
			KEY_START2: kb_start2_ref           = pressed;
			default: begin
			end
		endcase
	endtask

	// Starts at a falling edge and ends after the status read
	task automatic check_controls();
		ctrl_t     merged;
		apb_data_t rd;
		merged = kb_ctrl_ref | joy0[CTRL_W-1:0] | joy1[CTRL_W-1:0];
		check(32'(game_ctrl_n), 32'(expected_ctrl_n(merged, rotate_ref)), "game_ctrl_n");
		check(32'(game_sw), 32'({kb_start2_ref, kb_start1_ref, kb_coin_ref}), "game_sw");
		apb_read(ADDR_STATUS, rd);
		check(rd, 32'({kb_start2_ref, kb_start1_ref, kb_coin_ref, merged}), "STATUS read");
	endtask

	// ============================================================
	// Video checker and timeout
	// ============================================================
	always @(negedge clk_sys) begin
		if (!rst_n) begin
			vga_pending = 1'b0;
			ce_seen     = 1'b0;
			since_ce    = 0;
		end else begin
			if (vga_pending) begin
				check(32'({vga_r, vga_g, vga_b}), 32'(vga_expected), "vga colour after ce_pix");
			end
			since_ce    = since_ce + 1;
			vga_pending = ce_pix;
			if (ce_pix) begin
				vga_expected = expected_rgb(core_r, core_g, core_b, hblank | vblank);
				if (ce_seen) begin
					check(32'(since_ce), 32'(CE_DIV), "ce_pix spacing");
				end else begin
					check(32'(since_ce <= CE_DIV), 32'd1, "first ce_pix after reset");
				end
				ce_seen  = 1'b1;
				since_ce = 0;
			end else begin
				check(32'(since_ce < CE_DIV), 32'd1, "ce_pix pulse missing");
			end
		end
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("Timeout: the tests did not finish within %0d clock cycles", TIMEOUT_CYCLES);
			$display("Simulation failed");
			$fatal(1, "Timeout");
		end
	end

	// ============================================================
	// Test sequence
	// ============================================================
	initial begin
		apb_data_t rd;
		apb_addr_t bad_addr;
		int        ones;
		int        diff;
		audio_t    level;

		seed          = 32'h04321161;
		rst_n         = 1'b0;
		key_event     = '0;
		joy0          = '0;
		joy1          = '0;
		psel          = 1'b0;
		penable       = 1'b0;
		pwrite        = 1'b0;
		paddr         = '0;
		pwdata        = '0;
		core_r        = '0;
		core_g        = '0;
		core_b        = '0;
		hblank        = 1'b0;
		vblank        = 1'b0;
		audio_in      = '0;
		kb_ctrl_ref   = '0;
		kb_coin_ref   = 1'b0;
		kb_start1_ref = 1'b0;
		kb_start2_ref = 1'b0;
		toggle_bit    = 1'b0;
		ctrl_ref      = '0;
		rotate_ref    = 1'b0;
		known_keys    = '{KEY_UP, KEY_DOWN, KEY_LEFT, KEY_RIGHT,
			KEY_FIRE, KEY_COIN, KEY_START1, KEY_START2};
		audio_levels  = '{8'd0, 8'd1, 8'd37, 8'd128, 8'd255};

		// Reset values checked while reset is still held
		repeat (7) @(posedge clk_sys);
		@(negedge clk_sys);
		check(32'(game_ctrl_n), 32'h1f, "game_ctrl_n in reset");
		check(32'({game_sw, core_reset, scanlines, ce_pix}), 32'd0, "controls in reset");
		check(32'({vga_r, vga_g, vga_b, audio_out}), 32'd0, "video and audio in reset");
		@(posedge clk_sys);
		rst_n <= 1'b1;
		apb_read(ADDR_CTRL, rd);
		check(rd, 32'd0, "CTRL after reset");

		// Keyboard events including unknown codes
		for (int i = 0; i < KEY_EVENTS; i++) begin
			rnd = $random(seed);
			if (rnd[7:6] != 2'b00) begin
				send_key(known_keys[rnd[2:0]], rnd[4]);
			end else begin
				send_key(rnd[15:8], rnd[4]);
			end
			repeat (3) @(posedge clk_sys);
			@(negedge clk_sys);
			check_controls();
		end

		// Joystick merge upright and then rotated
		for (int pass = 0; pass < 2; pass++) begin
			if (pass == 1) begin
				apb_write(ADDR_CTRL, 32'h2);
				ctrl_ref   = 4'h2;
				rotate_ref = 1'b1;
			end
			for (int i = 0; i < JOY_STEPS; i++) begin
				rnd = $random(seed);
				@(posedge clk_sys);
				joy0 <= rnd[7:0];
				joy1 <= rnd[15:8];
				if (rnd[16]) begin
					send_key(known_keys[rnd[19:17]], rnd[20]);
				end
				repeat (3) @(posedge clk_sys);
				@(negedge clk_sys);
				check_controls();
			end
		end

		// CTRL writes and unmapped offsets
		for (int i = 0; i < REG_WRITES; i++) begin
			rnd = $random(seed);
			apb_write(ADDR_CTRL, rnd);
			ctrl_ref   = rnd[3:0];
			rotate_ref = ctrl_ref[CTRL_ROTATE_BIT];
			@(negedge clk_sys);
			check(32'(core_reset), 32'(ctrl_ref[CTRL_RESET_BIT]), "core_reset");
			check(32'(scanlines), 32'(ctrl_ref[CTRL_SCAN_LSB +: 2]), "scanlines");
			apb_read(ADDR_CTRL, rd);
			check(rd, 32'(ctrl_ref), "CTRL read back");
			@(negedge clk_sys);
			check_controls(); // Rotation seen through the core controls
			rnd = $random(seed);
			bad_addr = rnd[3:0];
			if (bad_addr == ADDR_CTRL || bad_addr == ADDR_STATUS) begin
				bad_addr = 4'h8;
			end
			apb_write(bad_addr, $random(seed));
			apb_read(ADDR_CTRL, rd);
			check(rd, 32'(ctrl_ref), "CTRL after unmapped write");
			apb_read(bad_addr, rd);
			check(rd, 32'd0, "unmapped read");
		end
		apb_write(ADDR_CTRL, 32'h0);
		ctrl_ref   = '0;
		rotate_ref = 1'b0;

		// Random colours and blanking held for a few pixels
		for (int i = 0; i < PIXEL_STEPS; i++) begin
			rnd = $random(seed);
			@(posedge clk_sys);
			core_r <= rnd[2:0];
			core_g <= rnd[5:3];
			core_b <= rnd[7:6];
			hblank <= (rnd[10:8] == 3'd0);
			vblank <= (rnd[13:11] == 3'd0);
			repeat (3 * CE_DIV + int'(rnd[15:14])) @(posedge clk_sys);
		end

		// Audio density over 256 bits
		for (int i = 0; i < 6; i++) begin
			rnd = $random(seed);
			level = (i < 5) ? audio_levels[i] : rnd[7:0];
			@(posedge clk_sys);
			audio_in <= level;
			repeat (300) @(posedge clk_sys);
			ones = 0;
			for (int c = 0; c < 256; c++) begin
				@(negedge clk_sys);
				if (audio_out) begin
					ones++;
				end
			end
			diff = ones - int'(level);
			check(32'(diff >= -1 && diff <= 1), 32'd1, "audio ones count");
		end

		if (arcade_frontend_inst.arcade_frontend_assert_inst.fail_count != 0) begin
			$display("Bound assertions failed %0d times",
				arcade_frontend_inst.arcade_frontend_assert_inst.fail_count);
			$display("Simulation failed");
			$fatal(1, "Assertion failures");
		end else begin
			$display("Simulation completed successfully");
			$finish;
		end
	end

endmodule

//--- compile.f
logic/arcade_pkg.sv
logic/host_pkg.sv
logic/ps2_key_decoder.sv
logic/control_mapper.sv
logic/host_regs.sv
logic/pixel_gate.sv
logic/sigma_delta_dac.sv
logic/arcade_frontend.sv
dv/arcade_frontend_assert.sv
dv/arcade_frontend_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the arcade frontend testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f \
	--top-module arcade_frontend_tb -o arcade_frontend_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/arcade_frontend_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
	echo "Simulator exited with status $run_status"
	exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
